// File: cpu_defs.svh
// Core widths and register file sizing shared by every pipeline stage
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath
`define CPU_XLEN        32      // Data and word address width
`define CPU_REG_ADDR_W  5
`define CPU_REG_COUNT   32

// Instruction fields
`define CPU_IMM_W       17      // Signed immediate in bits 16..0
`define CPU_OPCODE_W    5       // Opcode and ALU function share this width
`define CPU_TARGET_W    27      // Absolute jump target

`endif

// File: cpu_pkg.sv
// Opcode, ALU function and forwarding types plus the pipeline register layouts
`include "cpu_defs.svh"

package cpu_pkg;

    typedef enum logic [`CPU_OPCODE_W-1:0] {
        OP_RTYPE = 5'd0,
        OP_J     = 5'd1,
        OP_BNE   = 5'd2,
        OP_ADDI  = 5'd5,
        OP_SW    = 5'd7,
        OP_LW    = 5'd8
    } opcode_e;

    typedef enum logic [`CPU_OPCODE_W-1:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG,    // Value read in decode
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] instr;    // All zero is a bubble
    } if_id_t;

    typedef struct packed {
        logic                       valid;
        logic [`CPU_XLEN-1:0]       pc;         // Base for the bne target
        logic [`CPU_REG_ADDR_W-1:0] rs_idx;     // Source of operand A
        logic [`CPU_REG_ADDR_W-1:0] rd_idx;
        logic [`CPU_REG_ADDR_W-1:0] rb_idx;     // Source of operand B
        logic [`CPU_XLEN-1:0]       op_a;
        logic [`CPU_XLEN-1:0]       op_b;
        logic [`CPU_XLEN-1:0]       imm;        // Already sign-extended
        alu_op_e                    alu_op;
        logic [`CPU_REG_ADDR_W-1:0] shamt;
        logic                       uses_imm;
        logic                       is_load;
        logic                       is_store;
        logic                       is_branch;
        logic                       writes_reg;
    } id_ex_t;

    typedef struct packed {
        logic                       valid;
        logic [`CPU_XLEN-1:0]       result;     // ALU result or memory address
        logic [`CPU_XLEN-1:0]       store_data;
        logic [`CPU_REG_ADDR_W-1:0] dest;
        logic                       is_load;
        logic                       is_store;
        logic                       writes_reg;
    } ex_mem_t;

    typedef struct packed {
        logic                       valid;
        logic [`CPU_XLEN-1:0]       data;
        logic [`CPU_REG_ADDR_W-1:0] dest;
        logic                       writes_reg;
    } mem_wb_t;

endpackage

// File: fetch_stage.sv
// Instruction fetch with program counter, redirect choice and the IF/ID register
`timescale 1ns/1ps
`include "cpu_defs.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic                 clock,
    input  logic                 fft_reset,
    input  logic                 stall,
    input  logic                 jump_taken,
    input  logic [`CPU_XLEN-1:0] jump_target,
    input  logic                 branch_taken,
    input  logic [`CPU_XLEN-1:0] branch_target,
    input  logic                 flush_id,
    output logic [`CPU_XLEN-1:0] imem_addr,
    input  logic [`CPU_XLEN-1:0] imem_data,
    output if_id_t               if_id
);
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] pc_next;

    assign imem_addr = pc;

    // Branch in EX is older than the jump in ID, so it wins
    always_comb begin
        if (branch_taken)
            pc_next = branch_target;
        else if (jump_taken)
            pc_next = jump_target;      // Redirects even while decode is held
        else if (stall)
            pc_next = pc;
        else
            pc_next = pc + `CPU_XLEN'(1);
    end

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            pc    <= '0;
            if_id <= '0;
        end else begin
            pc <= pc_next;
            if (flush_id)
                if_id <= '0;            // Zero word decodes as add r0
            else if (!stall)
                if_id <= '{pc: pc, instr: imem_data};
        end
    end

endmodule

// File: register_file.sv
// 32-entry register file with two read ports, write-through and r0 tied to zero
`timescale 1ns/1ps
`include "cpu_defs.svh"

module register_file import cpu_pkg::*; (
    input  logic                       clock,
    input  logic                       fft_reset,
    input  logic [`CPU_REG_ADDR_W-1:0] read_a_idx,
    input  logic [`CPU_REG_ADDR_W-1:0] read_b_idx,
    output logic [`CPU_XLEN-1:0]       read_a,
    output logic [`CPU_XLEN-1:0]       read_b,
    input  mem_wb_t                    wb
);
    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];
    logic                 wr_en;

    assign wr_en = wb.valid && wb.writes_reg && (wb.dest != '0);   // r0 never written

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // Same-cycle write is visible to decode
    assign read_a = (read_a_idx == '0) ? '0 :
                    (wr_en && read_a_idx == wb.dest) ? wb.data : regs[read_a_idx];
    assign read_b = (read_b_idx == '0) ? '0 :
                    (wr_en && read_b_idx == wb.dest) ? wb.data : regs[read_b_idx];

endmodule

// File: decode_stage.sv
// Instruction decode with field split, control flags, jump detection and ID/EX register
`timescale 1ns/1ps
`include "cpu_defs.svh"

module decode_stage import cpu_pkg::*; (
    input  logic                       clock,
    input  logic                       fft_reset,
    input  logic                       stall,
    input  logic                       flush_ex,
    input  if_id_t                     if_id,
    output logic [`CPU_REG_ADDR_W-1:0] read_a_idx,
    output logic [`CPU_REG_ADDR_W-1:0] read_b_idx,
    input  logic [`CPU_XLEN-1:0]       read_a,
    input  logic [`CPU_XLEN-1:0]       read_b,
    output logic                       jump_taken,
    output logic [`CPU_XLEN-1:0]       jump_target,
    output id_ex_t                     id_ex
);
    opcode_e                    op;
    logic [`CPU_REG_ADDR_W-1:0] rd;
    logic [`CPU_REG_ADDR_W-1:0] rs;
    logic [`CPU_REG_ADDR_W-1:0] rt;
    logic [`CPU_OPCODE_W-1:0]   funct;
    id_ex_t                     decoded;

    assign op    = opcode_e'(if_id.instr[31:27]);
    assign rd    = if_id.instr[26:22];
    assign rs    = if_id.instr[21:17];
    assign rt    = if_id.instr[16:12];
    assign funct = if_id.instr[6:2];

    // bne compares rd with rs, sw stores rd
    assign read_a_idx = (op == OP_BNE) ? rd : rs;
    assign read_b_idx = (op == OP_BNE) ? rs : (op == OP_SW) ? rd : rt;

    assign jump_taken  = (op == OP_J);
    assign jump_target = {{(`CPU_XLEN-`CPU_TARGET_W){1'b0}}, if_id.instr[`CPU_TARGET_W-1:0]};

    always_comb begin
        decoded        = '0;
        decoded.valid  = 1'b1;
        decoded.pc     = if_id.pc;
        decoded.rs_idx = read_a_idx;
        decoded.rd_idx = rd;
        decoded.rb_idx = read_b_idx;
        decoded.op_a   = read_a;
        decoded.op_b   = read_b;
        decoded.imm    = {{(`CPU_XLEN-`CPU_IMM_W){if_id.instr[`CPU_IMM_W-1]}},
                          if_id.instr[`CPU_IMM_W-1:0]};
        decoded.alu_op = ALU_ADD;               // Address math for lw and sw
        decoded.shamt  = if_id.instr[11:7];
        case (op)
            OP_RTYPE: begin
                decoded.alu_op     = alu_op_e'(funct);
                decoded.writes_reg = 1'b1;
            end
            OP_ADDI: begin
                decoded.uses_imm   = 1'b1;
                decoded.writes_reg = 1'b1;
            end
            OP_LW: begin
                decoded.uses_imm   = 1'b1;
                decoded.is_load    = 1'b1;
                decoded.writes_reg = 1'b1;
            end
            OP_SW: begin
                decoded.uses_imm = 1'b1;
                decoded.is_store = 1'b1;
            end
            OP_BNE:  decoded.is_branch = 1'b1;
            default: decoded.writes_reg = 1'b0; // j and unknown opcodes have no effect here
        endcase
    end

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset)
            id_ex <= '0;
        else if (stall || flush_ex)
            id_ex <= '0;                        // Bubble
        else
            id_ex <= decoded;
    end

endmodule

// File: hazard_unit.sv
// Forwarding selects, load-use stall and flush control for the pipeline
`timescale 1ns/1ps
`include "cpu_defs.svh"

module hazard_unit import cpu_pkg::*; (
    input  logic [`CPU_REG_ADDR_W-1:0] id_rs,
    input  logic [`CPU_REG_ADDR_W-1:0] id_rb,
    input  id_ex_t                     id_ex,
    input  ex_mem_t                    ex_mem,
    input  mem_wb_t                    mem_wb,
    input  logic                       branch_taken,
    input  logic                       jump_taken,
    output logic                       stall,
    output fwd_sel_e                   fwd_a,
    output fwd_sel_e                   fwd_b,
    output logic                       flush_id,
    output logic                       flush_ex
);
    // Youngest producer first, r0 is never forwarded
    function automatic fwd_sel_e pick_src(input logic [`CPU_REG_ADDR_W-1:0] idx,
                                          input ex_mem_t m, input mem_wb_t w);
        if (m.valid && m.writes_reg && m.dest != '0 && m.dest == idx)
            return FWD_MEM;
        if (w.valid && w.writes_reg && w.dest != '0 && w.dest == idx)
            return FWD_WB;
        return FWD_REG;
    endfunction

    assign fwd_a = pick_src(id_ex.rs_idx, ex_mem, mem_wb);
    assign fwd_b = pick_src(id_ex.rb_idx, ex_mem, mem_wb);

    // Load result is not ready until WB for a consumer directly behind it
    assign stall = id_ex.valid && id_ex.is_load && id_ex.writes_reg && (id_ex.rd_idx != '0) &&
                   (id_ex.rd_idx == id_rs || id_ex.rd_idx == id_rb);

    assign flush_id = jump_taken || branch_taken;
    assign flush_ex = branch_taken;             // Kills the instruction in ID

endmodule

// File: execute_stage.sv
// Execute stage with forwarding muxes, ALU, bne resolution and the EX/MEM register
`timescale 1ns/1ps
`include "cpu_defs.svh"

module execute_stage import cpu_pkg::*; (
    input  logic                 clock,
    input  logic                 fft_reset,
    input  id_ex_t               id_ex,
    input  fwd_sel_e             fwd_a,
    input  fwd_sel_e             fwd_b,
    input  logic [`CPU_XLEN-1:0] mem_fwd,
    input  logic [`CPU_XLEN-1:0] wb_fwd,
    output logic                 branch_taken,
    output logic [`CPU_XLEN-1:0] branch_target,
    output ex_mem_t              ex_mem
);
    logic [`CPU_XLEN-1:0] src_a;
    logic [`CPU_XLEN-1:0] src_b;
    logic [`CPU_XLEN-1:0] alu_b;
    logic [`CPU_XLEN-1:0] alu_result;

    function automatic logic [`CPU_XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                     input logic [`CPU_XLEN-1:0] reg_val,
                                                     input logic [`CPU_XLEN-1:0] mem_val,
                                                     input logic [`CPU_XLEN-1:0] wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a = fwd_mux(fwd_a, id_ex.op_a, mem_fwd, wb_fwd);
    assign src_b = fwd_mux(fwd_b, id_ex.op_b, mem_fwd, wb_fwd);
    assign alu_b = id_ex.uses_imm ? id_ex.imm : src_b;

    // Arithmetic wraps, no overflow detection
    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_result = src_a + alu_b;
            ALU_SUB: alu_result = src_a - alu_b;
            ALU_AND: alu_result = src_a & alu_b;
            ALU_OR:  alu_result = src_a | alu_b;
            ALU_SLL: alu_result = src_a << id_ex.shamt;
            ALU_SRA: alu_result = $signed(src_a) >>> id_ex.shamt;
            default: alu_result = src_a + alu_b;
        endcase
    end

    // bne operands are rd in A and rs in B
    assign branch_taken  = id_ex.valid && id_ex.is_branch && (src_a != src_b);
    assign branch_target = id_ex.pc + `CPU_XLEN'(1) + id_ex.imm;

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.result     <= alu_result;
            ex_mem.store_data <= src_b;         // Forwarded rd for sw
            ex_mem.dest       <= id_ex.rd_idx;
            ex_mem.is_load    <= id_ex.is_load;
            ex_mem.is_store   <= id_ex.is_store;
            ex_mem.writes_reg <= id_ex.writes_reg;
        end
    end

endmodule

// File: memory_stage.sv
// Memory stage driving the data port, choosing load or ALU data, and the MEM/WB register
`timescale 1ns/1ps
`include "cpu_defs.svh"

module memory_stage import cpu_pkg::*; (
    input  logic                 clock,
    input  logic                 fft_reset,
    input  ex_mem_t              ex_mem,
    output logic [`CPU_XLEN-1:0] dmem_addr,
    output logic [`CPU_XLEN-1:0] dmem_wdata,
    output logic                 dmem_we,
    input  logic [`CPU_XLEN-1:0] dmem_rdata,
    output logic [`CPU_XLEN-1:0] mem_fwd,
    output mem_wb_t              mem_wb
);
    assign dmem_addr  = ex_mem.result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.valid && ex_mem.is_store;

    // Memory answers in the same cycle
    assign mem_fwd = ex_mem.is_load ? dmem_rdata : ex_mem.result;

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            mem_wb <= '0;
        end else begin
            mem_wb.valid      <= ex_mem.valid;
            mem_wb.data       <= mem_fwd;
            mem_wb.dest       <= ex_mem.dest;
            mem_wb.writes_reg <= ex_mem.writes_reg;   // Write request for the register file
        end
    end

endmodule

// File: cpu_top.sv
// Five-stage pipelined integer core connecting fetch, decode, execute, memory and hazard logic
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_top import cpu_pkg::*; (
    input  logic                 clock,
    input  logic                 fft_reset,
    output logic [`CPU_XLEN-1:0] imem_addr,
    input  logic [`CPU_XLEN-1:0] imem_data,
    output logic [`CPU_XLEN-1:0] dmem_addr,
    output logic [`CPU_XLEN-1:0] dmem_wdata,
    output logic                 dmem_we,
    input  logic [`CPU_XLEN-1:0] dmem_rdata
);
    if_id_t                     if_id;
    id_ex_t                     id_ex;
    ex_mem_t                    ex_mem;
    mem_wb_t                    mem_wb;
    logic [`CPU_REG_ADDR_W-1:0] read_a_idx;
    logic [`CPU_REG_ADDR_W-1:0] read_b_idx;
    logic [`CPU_XLEN-1:0]       read_a;
    logic [`CPU_XLEN-1:0]       read_b;
    logic                       stall;
    logic                       flush_id;
    logic                       flush_ex;
    logic                       jump_taken;
    logic [`CPU_XLEN-1:0]       jump_target;
    logic                       branch_taken;
    logic [`CPU_XLEN-1:0]       branch_target;
    fwd_sel_e                   fwd_a;
    fwd_sel_e                   fwd_b;
    logic [`CPU_XLEN-1:0]       mem_fwd;

    fetch_stage u_fetch (
        .clock(clock), .fft_reset(fft_reset), .stall(stall),
        .jump_taken(jump_taken), .jump_target(jump_target),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .flush_id(flush_id), .imem_addr(imem_addr), .imem_data(imem_data), .if_id(if_id)
    );

    register_file u_regs (
        .clock(clock), .fft_reset(fft_reset),
        .read_a_idx(read_a_idx), .read_b_idx(read_b_idx),
        .read_a(read_a), .read_b(read_b), .wb(mem_wb)
    );

    decode_stage u_decode (
        .clock(clock), .fft_reset(fft_reset), .stall(stall), .flush_ex(flush_ex),
        .if_id(if_id), .read_a_idx(read_a_idx), .read_b_idx(read_b_idx),
        .read_a(read_a), .read_b(read_b),
        .jump_taken(jump_taken), .jump_target(jump_target), .id_ex(id_ex)
    );

    hazard_unit u_hazard (
        .id_rs(read_a_idx), .id_rb(read_b_idx),
        .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
        .branch_taken(branch_taken), .jump_taken(jump_taken),
        .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .flush_id(flush_id), .flush_ex(flush_ex)
    );

    execute_stage u_execute (
        .clock(clock), .fft_reset(fft_reset), .id_ex(id_ex),
        .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_fwd(mem_fwd), .wb_fwd(mem_wb.data),      // WB value is the MEM/WB payload
        .branch_taken(branch_taken), .branch_target(branch_target), .ex_mem(ex_mem)
    );

    memory_stage u_memory (
        .clock(clock), .fft_reset(fft_reset), .ex_mem(ex_mem),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata), .mem_fwd(mem_fwd), .mem_wb(mem_wb)
    );

endmodule

// File: tb_cpu.sv
// Testbench for the pipelined core with program generator, ISA reference model and store checker
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_cpu import cpu_pkg::*; ();

    localparam int IMEM_WORDS  = 1024;
    localparam int DMEM_WORDS  = 1024;
    localparam int RESULT_BASE = 200;      // Closing stores of r1..r15 land here
    localparam int REF_STEPS   = 4000;

    logic                 clock;
    logic                 fft_reset;
    logic [`CPU_XLEN-1:0] imem_addr;
    logic [`CPU_XLEN-1:0] imem_data;
    logic [`CPU_XLEN-1:0] dmem_addr;
    logic [`CPU_XLEN-1:0] dmem_wdata;
    logic                 dmem_we;
    logic [`CPU_XLEN-1:0] dmem_rdata;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          exp_count;
    int          stores_seen;
    int          prog_len;
    int          wd_count;
    int          wd_limit;
    integer      seed;
    string       test_name;

    cpu_top dut (
        .clock(clock), .fft_reset(fft_reset),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata)
    );

    always #5 clock = ~clock;

    function automatic void report_failure(string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endfunction

    // Every word of data memory gets a value tied to its full address
    function automatic logic [31:0] fill_word(int addr);
        return (32'(addr) * 32'h9e3779b1) ^ 32'h0badf00d;
    endfunction

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Memory models answer reads in the same cycle
    assign imem_data  = imem[imem_addr[9:0]];
    assign dmem_rdata = dmem[dmem_addr[9:0]];

    always @(posedge clock) begin
        if (fft_reset) begin
            for (int i = 0; i < DMEM_WORDS; i++)
                dmem[10'(i)] <= fill_word(i);
        end else if (dmem_we) begin
            dmem[dmem_addr[9:0]] <= dmem_wdata;
        end
    end

    // Instruction assembly
    function automatic logic [31:0] enc_r(alu_op_e fn, int rd, int rs, int rt, int sh);
        return {OP_RTYPE, 5'(rd), 5'(rs), 5'(rt), 5'(sh), fn, 2'b00};
    endfunction

    function automatic logic [31:0] enc_i(opcode_e op, int rd, int rs, int imm);
        return {op, 5'(rd), 5'(rs), 17'(imm)};
    endfunction

    function automatic logic [31:0] enc_j(int target);
        return {OP_J, 27'(target)};
    endfunction

    function automatic void emit(logic [31:0] word);
        imem[10'(prog_len)] = word;
        prog_len++;
    endfunction

    function automatic void emit_epilogue();
        for (int r = 1; r < 16; r++)
            emit(enc_i(OP_SW, r, 0, RESULT_BASE + r));
        emit(enc_j(prog_len));                  // Park on itself
    endfunction

    // ISA model that lists every store the program makes, in order
    function automatic void run_reference();
        logic [31:0] regs [32];
        logic [31:0] mem [DMEM_WORDS];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] imm;
        logic [31:0] vd;
        logic [31:0] vs;
        logic [31:0] vt;
        logic [31:0] res;
        logic        wr;
        int          steps;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            mem[i] = fill_word(i);
        pc = '0;
        for (steps = 0; steps < REF_STEPS; steps++) begin
            w   = imem[pc[9:0]];
            vd  = regs[w[26:22]];
            vs  = regs[w[21:17]];
            vt  = regs[w[16:12]];
            imm = {{15{w[16]}}, w[16:0]};
            wr  = 1'b0;
            res = '0;
            if (opcode_e'(w[31:27]) == OP_J && {5'b0, w[26:0]} == pc)
                break;
            pc = pc + 32'd1;
            case (opcode_e'(w[31:27]))
                OP_RTYPE: begin
                    wr = 1'b1;
                    case (alu_op_e'(w[6:2]))
                        ALU_ADD: res = vs + vt;
                        ALU_SUB: res = vs - vt;
                        ALU_AND: res = vs & vt;
                        ALU_OR:  res = vs | vt;
                        ALU_SLL: res = vs << w[11:7];
                        ALU_SRA: res = $signed(vs) >>> w[11:7];
                        default: report_failure("Program holds an unknown ALU function");
                    endcase
                end
                OP_ADDI: begin
                    wr  = 1'b1;
                    res = vs + imm;
                end
                OP_LW: begin
                    wr  = 1'b1;
                    res = mem[10'(vs + imm)];
                end
                OP_SW: begin
                    exp_addr.push_back(vs + imm);
                    exp_data.push_back(vd);
                    mem[10'(vs + imm)] = vd;
                end
                OP_BNE:  if (vd != vs) pc = pc + imm;   // pc already points past the bne
                OP_J:    pc = {5'b0, w[26:0]};
                default: report_failure("Program holds an unknown opcode");
            endcase
            if (wr && w[26:22] != 5'd0)
                regs[w[26:22]] = res;
        end
        if (steps >= REF_STEPS)
            report_failure("Reference model never reached the closing jump");
        exp_count = exp_addr.size();
    endfunction

    // Store checker
    always @(posedge clock) begin
        if (fft_reset) begin
            stores_seen <= 0;
        end else if (dmem_we) begin
            assert (stores_seen < exp_count) else
                report_failure($sformatf("Unexpected extra store in %s to address %h",
                                         test_name, dmem_addr));
            assert (dmem_addr == exp_addr[stores_seen]) else
                report_failure($sformatf("FAIL %s store %0d address: expected %h, actual %h",
                                         test_name, stores_seen, exp_addr[stores_seen],
                                         dmem_addr));
            assert (dmem_wdata == exp_data[stores_seen]) else
                report_failure($sformatf("FAIL %s store %0d data: expected %h, actual %h",
                                         test_name, stores_seen, exp_data[stores_seen],
                                         dmem_wdata));
            stores_seen <= stores_seen + 1;
        end
    end

    // Watchdog, budget set per program
    always @(posedge clock) begin
        if (fft_reset) begin
            wd_count <= 0;
        end else begin
            wd_count <= wd_count + 1;
            if (wd_count >= wd_limit)
                report_failure($sformatf("Timeout in %s: only %0d of %0d stores arrived",
                                         test_name, stores_seen, exp_count));
        end
    end

    task automatic begin_test(string name);
        @(posedge clock);
        fft_reset <= 1'b1;
        @(posedge clock);
        test_name = name;
        prog_len  = 0;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[10'(i)] = '0;
    endtask

    task automatic finish_test();
        emit_epilogue();
        run_reference();
        wd_limit = (40 * prog_len > 2000) ? 40 * prog_len : 2000;
        repeat (15) @(posedge clock);           // 16 reset cycles in total
        // Core sits at address 0 with no store pending while held in reset
        assert (imem_addr == '0) else
            report_failure($sformatf("FAIL %s reset pc: expected %h, actual %h",
                                     test_name, 32'h0, imem_addr));
        assert (dmem_we == 1'b0) else
            report_failure($sformatf("FAIL %s reset dmem_we: expected %b, actual %b",
                                     test_name, 1'b0, dmem_we));
        fft_reset <= 1'b0;
        wait (stores_seen == exp_count);
        repeat (8) @(posedge clock);            // Room for a stray store to show up
    endtask

    task automatic test_alu_chain();
        begin_test("alu_chain");
        emit(enc_i(OP_ADDI, 1, 0, 1234));
        emit(enc_i(OP_ADDI, 2, 0, -77));
        emit(enc_r(ALU_ADD, 3, 1, 2, 0));      // r2 from MEM, r1 from WB
        emit(enc_r(ALU_SUB, 4, 3, 1, 0));
        emit(enc_r(ALU_AND, 5, 4, 3, 0));      // MEM and WB together
        emit(enc_r(ALU_OR, 6, 5, 2, 0));
        emit(enc_r(ALU_SLL, 7, 6, 0, 9));
        emit(enc_r(ALU_SRA, 8, 7, 0, 5));
        emit(enc_r(ALU_SRA, 9, 2, 0, 31));
        emit(enc_r(ALU_SUB, 10, 8, 7, 0));
        emit(enc_r(ALU_ADD, 11, 10, 10, 0));
        finish_test();
    endtask

    task automatic test_addi_sign();
        begin_test("addi_sign");
        emit(enc_i(OP_ADDI, 1, 0, -1));
        emit(enc_i(OP_ADDI, 2, 1, -65536));    // Most negative immediate
        emit(enc_i(OP_ADDI, 3, 0, 65535));
        emit(enc_i(OP_ADDI, 4, 3, -65535));
        emit(enc_i(OP_ADDI, 5, 2, -12345));
        emit(enc_i(OP_ADDI, 6, 5, 1));
        finish_test();
    endtask

    task automatic test_load_use();
        begin_test("load_use");
        emit(enc_i(OP_ADDI, 1, 0, 77));
        emit(enc_i(OP_SW, 1, 0, 10));
        emit(enc_i(OP_LW, 2, 0, 10));
        emit(enc_r(ALU_ADD, 3, 2, 2, 0));      // Uses the load right away
        emit(enc_i(OP_LW, 4, 0, 11));
        emit(enc_i(OP_SW, 4, 0, 12));          // Store data is the fresh load
        emit(enc_i(OP_LW, 5, 0, 12));
        emit(enc_i(OP_ADDI, 6, 5, 1));
        emit(enc_i(OP_LW, 7, 1, -70));         // Base register plus negative offset
        emit(enc_r(ALU_SUB, 8, 7, 6, 0));
        emit(enc_i(OP_LW, 9, 0, 10));
        emit(enc_i(OP_BNE, 9, 1, 1));          // Equal, falls through
        emit(enc_i(OP_ADDI, 10, 9, 3));
        finish_test();
    endtask

    task automatic test_control();
        begin_test("control");
        emit(enc_i(OP_ADDI, 1, 0, 1));
        emit(enc_i(OP_ADDI, 2, 0, 2));
        emit(enc_i(OP_BNE, 1, 2, 2));          // Taken
        emit(enc_i(OP_ADDI, 3, 0, 99));
        emit(enc_i(OP_ADDI, 4, 0, 99));
        emit(enc_i(OP_ADDI, 5, 0, 5));
        emit(enc_i(OP_BNE, 5, 5, 3));          // Not taken
        emit(enc_i(OP_ADDI, 6, 0, 6));
        emit(enc_j(prog_len + 3));
        emit(enc_i(OP_ADDI, 7, 0, 77));
        emit(enc_i(OP_ADDI, 8, 0, 88));
        emit(enc_i(OP_ADDI, 9, 0, 9));
        emit(enc_i(OP_LW, 10, 0, 3));
        emit(enc_i(OP_BNE, 10, 0, 2));         // Load-use into a taken branch
        emit(enc_i(OP_ADDI, 11, 0, 111));
        emit(enc_i(OP_ADDI, 12, 0, 112));
        emit(enc_j(prog_len + 1));
        emit(enc_i(OP_ADDI, 13, 0, 13));
        emit(enc_i(OP_SW, 13, 0, 20));
        emit(enc_i(OP_BNE, 0, 13, 1));
        emit(enc_i(OP_ADDI, 14, 0, 14));
        emit(enc_i(OP_ADDI, 15, 0, 15));
        finish_test();
    endtask

    task automatic test_r0_writes();
        begin_test("r0_writes");
        emit(enc_i(OP_ADDI, 0, 0, 123));
        emit(enc_r(ALU_ADD, 1, 0, 0, 0));
        emit(enc_i(OP_ADDI, 0, 0, 5));
        emit(enc_i(OP_ADDI, 2, 0, 7));         // r0 must not be forwarded
        emit(enc_i(OP_SW, 0, 0, 30));
        emit(enc_i(OP_LW, 0, 0, 31));
        emit(enc_r(ALU_ADD, 3, 0, 0, 0));
        emit(enc_r(ALU_SLL, 0, 2, 0, 4));
        emit(enc_r(ALU_OR, 4, 0, 2, 0));
        finish_test();
    endtask

    task automatic test_random(int n);
        int body_len;
        int kind;
        int off;
        begin_test($sformatf("random_%0d", n));
        body_len = 20 + rand_below(21);
        for (int pc = 0; pc < body_len; pc++) begin
            kind = rand_below(10);
            off  = rand_below(4);
            if (off > body_len - pc - 1)
                off = body_len - pc - 1;           // Never jump past the closing stores
            case (kind)
                0, 1, 2: emit(enc_r(alu_op_e'(5'(rand_below(6))), rand_below(16),
                                    rand_below(16), rand_below(16), rand_below(32)));
                3, 4:    emit(enc_i(OP_ADDI, rand_below(16), rand_below(16), $random(seed)));
                5:       emit(enc_i(OP_LW, rand_below(16), 0, rand_below(64)));
                6:       emit(enc_i(OP_SW, rand_below(16), 0, rand_below(64)));
                7, 8:    emit(enc_i(OP_BNE, rand_below(16), rand_below(16), off));
                default: emit(enc_j(pc + 1 + off));
            endcase
        end
        finish_test();
    endtask

    initial begin
        clock     = 1'b0;
        fft_reset = 1'b1;
        seed      = 32'h9133aa3c;
        prog_len  = 0;
        exp_count = 0;
        wd_limit  = 2000;
        test_alu_chain();
        test_addi_sign();
        test_load_use();
        test_control();
        test_r0_writes();
        for (int n = 0; n < 50; n++)
            test_random(n);
        $display("test passed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
cpu_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

// File: Makefile
# Verilator build, run and lint of the pipelined core testbench

VERILATOR  ?= verilator
TOP        ?= tb_cpu
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --timescale 1ns/1ps -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
